//--- rv32i_consts.svh
`ifndef RV32I_CONSTS_SVH
`define RV32I_CONSTS_SVH

// data and address width
`define XLEN 32

// register index width and count
`define REG_ADDR_W 5
`define REG_COUNT 32

// first fetch address after reset
`define RESET_PC 32'h0000_0000

// canonical nop, encodes addi x0 x0 0
`define BUBBLE_INSTR 32'h0000_0013

`endif

//--- rv32i_pkg.sv
`include "rv32i_consts.svh"

package rv32i_pkg;

    // major opcodes of the kept subset
    typedef enum logic [6:0] {
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011,
        op_lui   = 7'b0110111,
        op_load  = 7'b0000011,
        op_store = 7'b0100011
    } opcode_t;

    // alu_add must stay zero so an all-zero control word is a bubble
    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or,  alu_and
    } alu_op_t;

    typedef enum logic [1:0] {
        fwd_none,  // register file value
        fwd_mem,   // alu result in memory stage
        fwd_wb     // final writeback value
    } fwd_sel_t;

    typedef enum logic {
        wb_alu,
        wb_mem
    } wb_sel_t;

    typedef struct packed {
        alu_op_t                alu_op;
        logic                   use_imm;
        logic [`XLEN-1:0]       imm;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] dest;
        logic                   mem_read;
        logic                   mem_write;
        logic                   wb_en;
        wb_sel_t                wb_sel;
    } ctrl_word_t;

    typedef struct packed {
        logic                   en;
        logic [`REG_ADDR_W-1:0] dest;
        logic [`XLEN-1:0]       data;
    } wb_t;

    typedef struct packed {
        logic             read;
        logic             write;
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] wdata;
    } dmem_req_t;

endpackage

//--- control_unit.sv
`timescale 1ns/1ps
`include "rv32i_consts.svh"

module control_unit (
    input  logic [`XLEN-1:0]      instr,
    output rv32i_pkg::ctrl_word_t ctrl
);
    import rv32i_pkg::*;

    opcode_t          opcode;
    logic [2:0]       funct3;
    logic             alt;       // instr[30] selects sub and sra
    logic [`XLEN-1:0] i_imm;
    logic [`XLEN-1:0] s_imm;
    logic [`XLEN-1:0] u_imm;
    alu_op_t          arith_op;

    assign opcode = opcode_t'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign alt    = instr[30];

    assign i_imm = {{20{instr[31]}}, instr[31:20]};
    assign s_imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign u_imm = {instr[31:12], 12'h000};

    // shared by register-immediate and register-register ops
    always_comb begin
        case (funct3)
            3'b000:  arith_op = (alt && opcode == op_reg) ? alu_sub : alu_add;
            3'b001:  arith_op = alu_sll;
            3'b010:  arith_op = alu_slt;
            3'b011:  arith_op = alu_sltu;
            3'b100:  arith_op = alu_xor;
            3'b101:  arith_op = alt ? alu_sra : alu_srl;
            3'b110:  arith_op = alu_or;
            default: arith_op = alu_and;
        endcase
    end

    always_comb begin
        ctrl = '0;  // bubble unless recognised
        case (opcode)
            op_imm: begin
                ctrl.alu_op  = arith_op;
                ctrl.use_imm = 1'b1;
                ctrl.imm     = i_imm;
                ctrl.rs1     = instr[19:15];
                ctrl.dest    = instr[11:7];
                ctrl.wb_en   = instr[11:7] != '0;
            end
            op_reg: begin
                ctrl.alu_op = arith_op;
                ctrl.rs1    = instr[19:15];
                ctrl.rs2    = instr[24:20];
                ctrl.dest   = instr[11:7];
                ctrl.wb_en  = instr[11:7] != '0;
            end
            op_lui: begin  // x0 + u_imm
                ctrl.use_imm = 1'b1;
                ctrl.imm     = u_imm;
                ctrl.dest    = instr[11:7];
                ctrl.wb_en   = instr[11:7] != '0;
            end
            op_load: begin
                if (funct3 == 3'b010) begin  // lw only
                    ctrl.use_imm  = 1'b1;
                    ctrl.imm      = i_imm;
                    ctrl.rs1      = instr[19:15];
                    ctrl.dest     = instr[11:7];
                    ctrl.mem_read = 1'b1;
                    ctrl.wb_en    = instr[11:7] != '0;
                    ctrl.wb_sel   = wb_mem;
                end
            end
            op_store: begin
                if (funct3 == 3'b010) begin  // sw only
                    ctrl.use_imm   = 1'b1;
                    ctrl.imm       = s_imm;
                    ctrl.rs1       = instr[19:15];
                    ctrl.rs2       = instr[24:20];
                    ctrl.mem_write = 1'b1;
                end
            end
            default: ctrl = '0;
        endcase
    end

endmodule

//--- regfile.sv
`timescale 1ns/1ps
`include "rv32i_consts.svh"

module regfile (
    input  logic                   clk,
    input  logic                   arst_n,
    input  rv32i_pkg::wb_t         wb,
    input  logic [`REG_ADDR_W-1:0] rs1,
    input  logic [`REG_ADDR_W-1:0] rs2,
    output logic [`XLEN-1:0]       rs1_data,
    output logic [`XLEN-1:0]       rs2_data
);

    logic [`XLEN-1:0] regs [1:`REG_COUNT-1];  // x0 has no storage

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en && wb.dest != '0) begin
            regs[wb.dest] <= wb.data;
        end
    end

    // write-through so decode sees the value written this cycle
    assign rs1_data = (rs1 == '0) ? '0 :
                      (wb.en && wb.dest == rs1) ? wb.data : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 :
                      (wb.en && wb.dest == rs2) ? wb.data : regs[rs2];

endmodule

//--- alu.sv
`timescale 1ns/1ps
`include "rv32i_consts.svh"

module alu (
    input  rv32i_pkg::alu_op_t op,
    input  logic [`XLEN-1:0]   a,
    input  logic [`XLEN-1:0]   b,
    output logic [`XLEN-1:0]   result
);
    import rv32i_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];  // rv32 shifts use five bits

    always_comb begin
        case (op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_sll:  result = a << shamt;
            alu_slt:  result = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            alu_sltu: result = {{(`XLEN-1){1'b0}}, a < b};
            alu_xor:  result = a ^ b;
            alu_srl:  result = a >> shamt;
            alu_sra:  result = $unsigned($signed(a) >>> shamt);
            alu_or:   result = a | b;
            alu_and:  result = a & b;
            default:  result = a + b;
        endcase
    end

endmodule

//--- hazard_unit.sv
`timescale 1ns/1ps
`include "rv32i_consts.svh"

module hazard_unit (
    input  rv32i_pkg::ctrl_word_t ex_ctrl,
    input  rv32i_pkg::ctrl_word_t id_ctrl,
    input  rv32i_pkg::ctrl_word_t mem_ctrl,
    input  rv32i_pkg::ctrl_word_t wb_ctrl,
    output rv32i_pkg::fwd_sel_t   fwd_a,
    output rv32i_pkg::fwd_sel_t   fwd_b,
    output logic                  load_use
);
    import rv32i_pkg::*;

    // producer writes a nonzero register matching src
    function automatic logic writes_reg(
        input ctrl_word_t             c,
        input logic [`REG_ADDR_W-1:0] src
    );
        return c.wb_en && c.dest != '0 && c.dest == src;
    endfunction

    // memory stage wins over writeback, loads in memory never forward
    function automatic fwd_sel_t pick_src(
        input logic [`REG_ADDR_W-1:0] src,
        input ctrl_word_t             mem_c,
        input ctrl_word_t             wb_c
    );
        if (writes_reg(mem_c, src) && !mem_c.mem_read) begin
            return fwd_mem;
        end
        if (writes_reg(wb_c, src)) begin
            return fwd_wb;
        end
        return fwd_none;
    endfunction

    assign fwd_a = pick_src(ex_ctrl.rs1, mem_ctrl, wb_ctrl);
    assign fwd_b = pick_src(ex_ctrl.rs2, mem_ctrl, wb_ctrl);

    // load in execute feeding the instruction in decode
    assign load_use = ex_ctrl.mem_read &&
                      (writes_reg(ex_ctrl, id_ctrl.rs1) ||
                       writes_reg(ex_ctrl, id_ctrl.rs2));

endmodule

//--- datapath.sv
`timescale 1ns/1ps
`include "rv32i_consts.svh"

module datapath (
    input  logic                 clk,
    input  logic                 arst_n,
    output logic [`XLEN-1:0]     inst_addr,
    input  logic [`XLEN-1:0]     inst_rdata,
    input  logic                 inst_resp,
    output rv32i_pkg::dmem_req_t dmem_req,
    input  logic [`XLEN-1:0]     data_rdata,
    input  logic                 data_resp
);
    import rv32i_pkg::*;

    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] id_instr;
    ctrl_word_t       id_ctrl;
    ctrl_word_t       ex_ctrl;
    ctrl_word_t       mem_ctrl;
    ctrl_word_t       wb_ctrl;
    logic [`XLEN-1:0] id_rs1_data;
    logic [`XLEN-1:0] id_rs2_data;
    logic [`XLEN-1:0] ex_rs1_data;
    logic [`XLEN-1:0] ex_rs2_data;
    logic [`XLEN-1:0] ex_op_a;
    logic [`XLEN-1:0] ex_rs2_fwd;   // also the store data
    logic [`XLEN-1:0] ex_op_b;
    logic [`XLEN-1:0] ex_alu;
    logic [`XLEN-1:0] mem_alu;
    logic [`XLEN-1:0] mem_store_data;
    logic [`XLEN-1:0] wb_alu;
    logic [`XLEN-1:0] wb_mem_data;
    wb_t              wb;
    fwd_sel_t         fwd_a;
    fwd_sel_t         fwd_b;
    logic             load_use;
    logic             advance;

    function automatic logic [`XLEN-1:0] fwd_mux(
        input fwd_sel_t         sel,
        input logic [`XLEN-1:0] reg_val,
        input logic [`XLEN-1:0] mem_val,
        input logic [`XLEN-1:0] wb_val
    );
        case (sel)
            fwd_mem: return mem_val;
            fwd_wb:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    // whole pipe waits on either memory
    assign advance = inst_resp && (!(dmem_req.read || dmem_req.write) || data_resp);
    assign inst_addr = pc;

    control_unit control_unit_inst (.instr(id_instr), .ctrl(id_ctrl));

    regfile regfile_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .wb       (wb),
        .rs1      (id_ctrl.rs1),
        .rs2      (id_ctrl.rs2),
        .rs1_data (id_rs1_data),
        .rs2_data (id_rs2_data)
    );

    hazard_unit hazard_unit_inst (
        .ex_ctrl  (ex_ctrl),
        .id_ctrl  (id_ctrl),
        .mem_ctrl (mem_ctrl),
        .wb_ctrl  (wb_ctrl),
        .fwd_a    (fwd_a),
        .fwd_b    (fwd_b),
        .load_use (load_use)
    );

    assign ex_op_a    = fwd_mux(fwd_a, ex_rs1_data, mem_alu, wb.data);
    assign ex_rs2_fwd = fwd_mux(fwd_b, ex_rs2_data, mem_alu, wb.data);
    assign ex_op_b    = ex_ctrl.use_imm ? ex_ctrl.imm : ex_rs2_fwd;

    alu alu_inst (.op(ex_ctrl.alu_op), .a(ex_op_a), .b(ex_op_b), .result(ex_alu));

    assign dmem_req.read  = mem_ctrl.mem_read;
    assign dmem_req.write = mem_ctrl.mem_write;
    assign dmem_req.addr  = mem_alu;
    assign dmem_req.wdata = mem_store_data;

    assign wb.en   = wb_ctrl.wb_en;
    assign wb.dest = wb_ctrl.dest;
    assign wb.data = (wb_ctrl.wb_sel == wb_mem) ? wb_mem_data : wb_alu;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc       <= `RESET_PC;
            id_instr <= `BUBBLE_INSTR;
            ex_ctrl  <= '0;
            mem_ctrl <= '0;
            wb_ctrl  <= '0;
        end else if (advance) begin
            if (!load_use) begin  // fetch and decode hold on load-use
                pc       <= pc + 32'd4;
                id_instr <= inst_rdata;
            end
            ex_ctrl  <= load_use ? ctrl_word_t'('0) : id_ctrl;  // bubble into execute
            mem_ctrl <= ex_ctrl;
            wb_ctrl  <= mem_ctrl;
        end
    end

    // data side of the stage registers
    always_ff @(posedge clk) begin
        if (advance) begin
            ex_rs1_data    <= id_rs1_data;
            ex_rs2_data    <= id_rs2_data;
            mem_alu        <= ex_alu;
            mem_store_data <= ex_rs2_fwd;
            wb_alu         <= mem_alu;
            wb_mem_data    <= data_rdata;
        end
    end

endmodule

//--- datapath_sva.sv
`timescale 1ns/1ps

module datapath_sva (
    input logic                 clk,
    input logic                 arst_n,
    input rv32i_pkg::dmem_req_t dmem_req,
    input logic                 data_resp
);

    int   sva_errors = 0;
    logic req_on;

    assign req_on = dmem_req.read || dmem_req.write;

    one_direction: assert property (@(posedge clk) disable iff (!arst_n)
        !(dmem_req.read && dmem_req.write))
        else begin
            sva_errors++;
            $error("data request has read and write high together");
        end

    // held request must not change until memory answers
    request_held: assert property (@(posedge clk) disable iff (!arst_n)
        (req_on && !data_resp) |=> $stable(dmem_req))
        else begin
            sva_errors++;
            $error("data request changed before data_resp");
        end

    reset_quiet: assert property (@(posedge clk) !arst_n |-> !req_on)
        else begin
            sva_errors++;
            $error("data request active while in reset");
        end

endmodule

bind datapath datapath_sva datapath_sva_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .dmem_req  (dmem_req),
    .data_resp (data_resp)
);

//--- tb_datapath.sv
`timescale 1ns/1ps
`include "rv32i_consts.svh"

module tb_datapath;
    import rv32i_pkg::*;

    logic             clk = 1'b0;
    logic             arst_n;
    logic [`XLEN-1:0] inst_addr;
    logic [`XLEN-1:0] inst_rdata;
    logic             inst_resp;
    dmem_req_t        dmem_req;
    logic [`XLEN-1:0] data_rdata;
    logic             data_resp;

    logic [`XLEN-1:0] imem [0:63];
    logic [`XLEN-1:0] dmem [0:255];   // 1 KiB of data space
    logic [`XLEN-1:0] init_addr [$];  // words the loads may target
    logic [`XLEN-1:0] exp_addr [$];
    logic [`XLEN-1:0] exp_data [$];
    string            exp_name [$];
    logic [31:0]      lfsr = 32'h71f2_d903;
    int               store_idx = 0;
    int               value_errors = 0;
    int               other_errors = 0;

    datapath datapath_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .inst_addr  (inst_addr),
        .inst_rdata (inst_rdata),
        .inst_resp  (inst_resp),
        .dmem_req   (dmem_req),
        .data_rdata (data_rdata),
        .data_resp  (data_resp)
    );

    always #20 clk = ~clk;

    // galois lfsr, one step per bit
    function automatic logic draw_bit();
        logic b;
        b    = lfsr[0];
        lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        return b;
    endfunction

    // respond unless both bits are zero
    task automatic roll_resp(output logic r);
        logic b0;
        logic b1;
        b0 = draw_bit();
        b1 = draw_bit();
        r = b0 | b1;
    endtask

    function automatic logic [`XLEN-1:0] fetch_word(input logic [`XLEN-1:0] addr);
        return (addr < 32'd256) ? imem[addr[7:2]] : `BUBBLE_INSTR;
    endfunction

    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        string       name;
        logic [31:0] addr;
        logic [31:0] w [4];
        for (int i = 0; i < 64; i++) begin
            imem[i] = `BUBBLE_INSTR;
        end
        for (int i = 0; i < 256; i++) begin
            dmem[i] = 32'h5a00_0000 | 32'(i * 4);  // word holds its own address
        end
        fd = $fopen("datapath_vectors.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("Error: could not open datapath_vectors.txt");
            return;
        end
        while (!$feof(fd)) begin
            if ($fgets(line, fd) == 0) break;
            if (line.len() < 2 || line[0] == "#") continue;
            case (line[0])
                "I": begin  // base address then four words
                    n = $sscanf(line, "I %h %h %h %h %h", addr, w[0], w[1], w[2], w[3]);
                    for (int k = 0; k < n - 1; k++) begin
                        imem[(addr >> 2) + k] = w[k];
                    end
                end
                "D": begin
                    n = $sscanf(line, "D %h %h", addr, w[0]);
                    dmem[addr[9:2]] = w[0];
                    init_addr.push_back(addr);
                end
                "S": begin
                    n = $sscanf(line, "S %h %h %s", addr, w[0], name);
                    exp_addr.push_back(addr);
                    exp_data.push_back(w[0]);
                    exp_name.push_back(name);
                end
                default: n = 0;
            endcase
            assert (n >= 2) else begin
                other_errors++;
                $display("Error: vector line could not be read: %s", line);
            end
        end
        $fclose(fd);
        assert (exp_addr.size() > 0) else begin
            other_errors++;
            $display("Error: vector file holds no expected stores");
        end
    endtask

    task automatic check_store(input logic [`XLEN-1:0] addr, input logic [`XLEN-1:0] data);
        dmem[addr[9:2]] = data;
        assert (store_idx < exp_addr.size()) else begin
            other_errors++;
            $display("Error: extra store of %h to %h after the expected stream", data, addr);
        end
        if (store_idx < exp_addr.size()) begin
            assert (addr == exp_addr[store_idx] && data == exp_data[store_idx]) else begin
                value_errors++;
                $display("Error %s: expected %h at %h, actual %h at %h", exp_name[store_idx],
                         exp_data[store_idx], exp_addr[store_idx], data, addr);
            end
            store_idx++;
        end
    endtask

    // loads only ever target initialized words
    task automatic check_load(input logic [`XLEN-1:0] addr);
        logic hit;
        hit = 1'b0;
        foreach (init_addr[i]) begin
            if (init_addr[i] == addr) hit = 1'b1;
        end
        assert (hit) else begin
            other_errors++;
            $display("Error: data read from %h, a word that no load in the program targets",
                     addr);
        end
    endtask

    // memory models, both sides sample the request before the edge
    always @(posedge clk) begin
        logic req_on;
        logic adv;
        logic r;
        req_on = dmem_req.read || dmem_req.write;
        adv    = inst_resp && (!req_on || data_resp);  // same rule as the pipeline
        if (!arst_n) begin
            inst_resp <= 1'b0;
            data_resp <= 1'b0;
        end else if (adv) begin
            if (dmem_req.write) check_store(dmem_req.addr, dmem_req.wdata);
            if (dmem_req.read) check_load(dmem_req.addr);
            inst_resp <= 1'b0;  // pc and request may move on this edge
            data_resp <= 1'b0;
        end else begin
            roll_resp(r);
            inst_rdata <= fetch_word(inst_addr);
            inst_resp  <= r;
            if (req_on) begin
                roll_resp(r);
                data_rdata <= dmem[dmem_req.addr[9:2]];
                data_resp  <= r;
            end else begin
                data_resp <= 1'b0;
            end
        end
    end

    initial begin
        int cycles;
        int sva_errors;
        arst_n     = 1'b0;
        inst_rdata = `BUBBLE_INSTR;
        inst_resp  = 1'b0;
        data_rdata = '0;
        data_resp  = 1'b0;
        load_vectors();
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
        cycles = 0;
        while (store_idx < exp_addr.size() && cycles < 2000) begin
            @(posedge clk);
            cycles++;
        end
        assert (store_idx == exp_addr.size()) else begin
            other_errors++;
            $display("Error: timed out after %0d cycles with %0d of %0d stores seen",
                     cycles, store_idx, exp_addr.size());
        end
        repeat (40) @(posedge clk);  // drain, catches any extra store
        sva_errors = datapath_inst.datapath_sva_inst.sva_errors;
        $display("errors: %0d value, %0d other, %0d assertion; stores seen %0d of %0d",
                 value_errors, other_errors, sva_errors, store_idx, exp_addr.size());
        if (value_errors + other_errors + sva_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- datapath_vectors.txt
# I <byte addr> <four program words>    D <byte addr> <initial data word>
# S <store addr> <store data> <test name>, listed in the order the stores must occur
I 000 123450b7 67808093 ffb00113 ffc12193
I 010 00513213 0ff0c293 7000e313 ff00f393
I 020 00409413 01c15493 40115513 10102023
I 030 10202223 10302423 10402623 10502823
I 040 10602a23 10702c23 10802e23 12902023
I 050 12a02223 002085b3 40b08633 00c096b3
I 060 00112733 001137b3 0020c833 00c158b3
I 070 40315933 008669b3 00887a33 15402623
I 080 12b02423 12c02623 12d02823 12e02a23
I 090 12f02c23 13002e23 15102023 15202223
I 0a0 15302423 12300013 14002823 08002a83
I 0b0 011a8b13 15602a23 08402b83 15702c23
D 080 0badf00d
D 084 600dcafe
S 100 12345678 lui_addi_fwd
S 104 fffffffb addi_neg
S 108 00000001 slti
S 10c 00000000 sltiu
S 110 12345687 xori
S 114 12345778 ori
S 118 12345670 andi
S 11c 23456780 slli
S 120 0000000f srli
S 124 fffffffd srai
S 14c 21412180 and_store_fwd
S 128 12345673 add
S 12c 00000005 sub_fwd
S 130 468acf00 sll_fwd
S 134 00000001 slt
S 138 00000000 sltu
S 13c edcba983 xor
S 140 07ffffff srl
S 144 fffffffd sra
S 148 23456785 or
S 150 00000000 x0_discard
S 154 0badf01e load_use_add
S 158 600dcafe load_use_store

//--- src.f
+incdir+.
rv32i_pkg.sv
control_unit.sv
regfile.sv
alu.sv
hazard_unit.sv
datapath.sv
datapath_sva.sv
tb_datapath.sv

//--- Bender.yml
package:
  name: rv32i_pipeline

sources:
  - include_dirs:
      - .
    files:
      - rv32i_pkg.sv
      - control_unit.sv
      - regfile.sv
      - alu.sv
      - hazard_unit.sv
      - datapath.sv
  - target: test
    include_dirs:
      - .
    files:
      - datapath_sva.sv
      - tb_datapath.sv
